/* dual_mem_stage_cfg.svh */
`ifndef DUAL_MEM_STAGE_CFG_SVH
`define DUAL_MEM_STAGE_CFG_SVH

////////////////////////////////////////
// Datapath

`define DMS_XLEN 32 // Data and address width

////////////////////////////////////////
// Scratchpad banks

`define DMS_DTIM_DEPTH 256 // Words per bank
`define DMS_DTIM_WAIT 2 // Request to ready, at least 1

`endif

/* mem_op_pkg.sv */
package mem_op_pkg;

  ////////////////////////////////////////
  // Lane operation

  typedef enum logic [2:0] {
    OP_NONE  = 3'd0,
    OP_ALU   = 3'd1,
    OP_LOAD  = 3'd2,
    OP_STORE = 3'd3,
    OP_FENCE = 3'd4
  } lane_op_e;

  typedef enum logic [1:0] {
    SZ_BYTE = 2'd0,
    SZ_HALF = 2'd1,
    SZ_WORD = 2'd2
  } lsu_size_e;

  typedef logic [4:0] reg_addr_t; // Destination register index

  // Needs a bank access
  function automatic logic op_is_mem(lane_op_e op);
    return (op == OP_LOAD) || (op == OP_STORE) || (op == OP_FENCE);
  endfunction

  // Writes the register file
  function automatic logic op_writes_reg(lane_op_e op);
    return (op == OP_ALU) || (op == OP_LOAD);
  endfunction

endpackage

/* mem_data_pkg.sv */
`include "dual_mem_stage_cfg.svh"

package mem_data_pkg;

  localparam int STRB_W = `DMS_XLEN / 8;

  ////////////////////////////////////////
  // Data and address

  typedef logic [`DMS_XLEN-1:0] word_t;
  typedef logic [`DMS_XLEN-1:0] addr_t;
  typedef logic [STRB_W-1:0] strb_t; // One bit per byte lane

  ////////////////////////////////////////
  // Write-back record

  typedef struct packed {
    logic wren;
    mem_op_pkg::reg_addr_t waddr;
    word_t wdata;
  } lane_result_t;

endpackage

/* lsu_align.sv */
`timescale 1ns/100ps

module lsu_align (
  input  mem_op_pkg::lsu_size_e size,
  input  logic unsigned_ld,
  input  logic [1:0] addr_lo,
  input  mem_data_pkg::word_t sdata,
  input  mem_data_pkg::word_t rdata,
  output mem_data_pkg::word_t wdata,
  output mem_data_pkg::strb_t wstrb,
  output mem_data_pkg::word_t ldata
);
  import mem_op_pkg::*;
  import mem_data_pkg::*;

  word_t shifted;
  logic sign;

  // Store side
  always_comb begin
    case (size)
      SZ_BYTE: begin
        wdata = {4{sdata[7:0]}};
        wstrb = strb_t'(4'b0001 << addr_lo);
      end
      SZ_HALF: begin
        wdata = {2{sdata[15:0]}};
        wstrb = addr_lo[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        wdata = sdata;
        wstrb = 4'b1111;
      end
    endcase
  end

  // Load side
  assign shifted = rdata >> {addr_lo, 3'b000};

  always_comb begin
    sign = 1'b0;
    case (size)
      SZ_BYTE: begin
        sign = ~unsigned_ld & shifted[7];
        ldata = {{($bits(word_t) - 8){sign}}, shifted[7:0]};
      end
      SZ_HALF: begin
        sign = ~unsigned_ld & shifted[15];
        ldata = {{($bits(word_t) - 16){sign}}, shifted[15:0]};
      end
      default: ldata = rdata;
    endcase
  end

  a_half_aligned: assert final (size !== SZ_HALF || addr_lo[0] !== 1'b1);

endmodule

/* dtim_wait_timer.sv */
`timescale 1ns/100ps

`include "dual_mem_stage_cfg.svh"

module dtim_wait_timer (
  input  logic clock,
  input  logic reset,
  input  logic start,
  output logic ready
);
  localparam int CNT_W = $clog2(`DMS_DTIM_WAIT) + 1;

  logic busy_q;
  logic [CNT_W-1:0] count_q;

  assign ready = busy_q & start & (count_q == '0);

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      busy_q <= 1'b0;
      count_q <= '0;
    end else if (!start || ready) begin
      busy_q <= 1'b0; // Aborted or done
    end else if (!busy_q) begin
      busy_q <= 1'b1;
      count_q <= CNT_W'(`DMS_DTIM_WAIT - 1);
    end else begin
      count_q <= count_q - 1'b1;
    end
  end

endmodule

/* dtim_bank.sv */
`timescale 1ns/100ps

`include "dual_mem_stage_cfg.svh"

module dtim_bank (
  input  logic clock,
  input  logic reset,
  input  logic mem_valid,
  input  logic mem_fence,
  input  mem_data_pkg::addr_t mem_addr,
  input  mem_data_pkg::word_t mem_wdata,
  input  mem_data_pkg::strb_t mem_wstrb,
  output logic mem_ready,
  output mem_data_pkg::word_t mem_rdata
);
  import mem_data_pkg::*;

  localparam int IDX_W = $clog2(`DMS_DTIM_DEPTH);

  word_t mem [`DMS_DTIM_DEPTH];
  logic [IDX_W-1:0] idx;

  assign idx = mem_addr[IDX_W+1:2]; // Word address

  dtim_wait_timer u_timer (
    .clock(clock),
    .reset(reset),
    .start(mem_valid),
    .ready(mem_ready)
  );

  ////////////////////////////////////////
  // Array access

  always_ff @(posedge clock) begin
    if (mem_ready && !mem_fence) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (mem_wstrb[b]) begin
          mem[idx][b*8 +: 8] <= mem_wdata[b*8 +: 8];
        end
      end
    end
  end

  assign mem_rdata = mem_ready ? mem[idx] : '0; // Valid in the ready cycle only

  // No reply before the wait states have passed
  a_ready_valid: assert property (
    @(posedge clock) disable iff (reset == 1'b0)
    mem_ready |-> mem_valid && $past(mem_valid, `DMS_DTIM_WAIT)
  );

endmodule

/* stage_ctrl_fsm.sv */
`timescale 1ns/100ps

module stage_ctrl_fsm (
  input  logic clock,
  input  logic reset,
  input  logic clear,
  input  logic l0_mem,
  input  logic l1_mem,
  input  logic l0_fence,
  input  logic ready0,
  input  logic ready1,
  output logic stall,
  output logic kill_l1,
  output logic issue
);
  typedef enum logic [1:0] {
    ST_RUN,
    ST_WAIT_MEM,
    ST_WAIT_FENCE
  } state_e;

  state_e state_q, state_d;

  assign kill_l1 = l0_fence || (state_q == ST_WAIT_FENCE);
  assign issue = ~clear; // Clear cancels the bank requests
  assign stall = ~clear & ((l0_mem & ~ready0) | (l1_mem & ~kill_l1 & ~ready1));

  always_comb begin
    state_d = state_q;
    if (clear) begin
      state_d = ST_RUN;
    end else begin
      case (state_q)
        ST_RUN: if (stall) state_d = l0_fence ? ST_WAIT_FENCE : ST_WAIT_MEM;
        default: if (!stall) state_d = ST_RUN;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      state_q <= ST_RUN;
    end else begin
      state_q <= state_d;
    end
  end

  // Upstream keeps the pending operation in place
  a_held: assert property (@(posedge clock) disable iff (reset == 1'b0)
    (state_q != ST_RUN) && !clear |-> l0_mem || l1_mem);
  // No stale access completes after a clear
  a_clear_unstalls: assert property (@(posedge clock) disable iff (reset == 1'b0)
    clear |=> !(ready0 || ready1));

endmodule

/* memory_stage.sv */
`timescale 1ns/100ps

module memory_stage (
  input  logic clock,
  input  logic reset,
  input  logic clear,
  input  mem_op_pkg::lane_op_e l0_op,
  input  mem_op_pkg::lsu_size_e l0_size,
  input  logic l0_unsigned_ld,
  input  mem_data_pkg::addr_t l0_addr,
  input  mem_data_pkg::word_t l0_data,
  input  mem_op_pkg::reg_addr_t l0_waddr,
  input  mem_op_pkg::lane_op_e l1_op,
  input  mem_op_pkg::lsu_size_e l1_size,
  input  logic l1_unsigned_ld,
  input  mem_data_pkg::addr_t l1_addr,
  input  mem_data_pkg::word_t l1_data,
  input  mem_op_pkg::reg_addr_t l1_waddr,
  output logic mem0_valid,
  output logic mem0_fence,
  output mem_data_pkg::addr_t mem0_addr,
  output mem_data_pkg::word_t mem0_wdata,
  output mem_data_pkg::strb_t mem0_wstrb,
  input  logic mem0_ready,
  input  mem_data_pkg::word_t mem0_rdata,
  output logic mem1_valid,
  output logic mem1_fence,
  output mem_data_pkg::addr_t mem1_addr,
  output mem_data_pkg::word_t mem1_wdata,
  output mem_data_pkg::strb_t mem1_wstrb,
  input  logic mem1_ready,
  input  mem_data_pkg::word_t mem1_rdata,
  output logic stall,
  output logic l0_res_wren,
  output mem_op_pkg::reg_addr_t l0_res_waddr,
  output mem_data_pkg::word_t l0_res_wdata,
  output logic l1_res_wren,
  output mem_op_pkg::reg_addr_t l1_res_waddr,
  output mem_data_pkg::word_t l1_res_wdata
);
  import mem_op_pkg::*;
  import mem_data_pkg::*;

  logic l0_mem, l1_mem, kill_l1, issue;
  logic l0_ldst, l1_ldst;
  word_t l0_wdata, l1_wdata, l0_ldata, l1_ldata;
  strb_t l0_wstrb, l1_wstrb;
  lane_result_t r0_d, r1_d, r0_q, r1_q;

  assign l0_mem = op_is_mem(l0_op);
  assign l1_mem = op_is_mem(l1_op);
  assign l0_ldst = (l0_op == OP_LOAD) || (l0_op == OP_STORE);
  assign l1_ldst = (l1_op == OP_LOAD) || (l1_op == OP_STORE);

  stage_ctrl_fsm u_ctrl (
    .clock(clock), .reset(reset), .clear(clear),
    .l0_mem(l0_mem), .l1_mem(l1_mem), .l0_fence(l0_op == OP_FENCE),
    .ready0(mem0_ready), .ready1(mem1_ready),
    .stall(stall), .kill_l1(kill_l1), .issue(issue)
  );

  // Offset only matters for loads and stores
  lsu_align u_align0 (
    .size(l0_size), .unsigned_ld(l0_unsigned_ld),
    .addr_lo(l0_ldst ? l0_addr[1:0] : 2'b00),
    .sdata(l0_data), .rdata(mem0_rdata),
    .wdata(l0_wdata), .wstrb(l0_wstrb), .ldata(l0_ldata)
  );

  lsu_align u_align1 (
    .size(l1_size), .unsigned_ld(l1_unsigned_ld),
    .addr_lo(l1_ldst ? l1_addr[1:0] : 2'b00),
    .sdata(l1_data), .rdata(mem1_rdata),
    .wdata(l1_wdata), .wstrb(l1_wstrb), .ldata(l1_ldata)
  );

  ////////////////////////////////////////
  // Bank requests

  assign mem0_valid = issue & l0_mem;
  assign mem0_fence = (l0_op == OP_FENCE);
  assign mem0_addr = l0_addr;
  assign mem0_wdata = l0_wdata;
  assign mem0_wstrb = (l0_op == OP_STORE) ? l0_wstrb : '0; // Zero strobe reads

  assign mem1_valid = issue & l1_mem & ~kill_l1; // Squashed behind a lane 0 fence
  assign mem1_fence = (l1_op == OP_FENCE);
  assign mem1_addr = l1_addr;
  assign mem1_wdata = l1_wdata;
  assign mem1_wstrb = (l1_op == OP_STORE) ? l1_wstrb : '0;

  ////////////////////////////////////////
  // Write-back registers

  always_comb begin
    r0_d.wren = op_writes_reg(l0_op) & ~stall & ~clear;
    r0_d.waddr = l0_waddr;
    r0_d.wdata = (l0_op == OP_LOAD) ? l0_ldata : l0_data;
    r1_d.wren = op_writes_reg(l1_op) & ~stall & ~clear & ~kill_l1;
    r1_d.waddr = l1_waddr;
    r1_d.wdata = (l1_op == OP_LOAD) ? l1_ldata : l1_data;
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      r0_q.wren <= 1'b0;
      r1_q.wren <= 1'b0;
    end else begin
      r0_q <= r0_d;
      r1_q <= r1_d;
    end
  end

  assign l0_res_wren = r0_q.wren;
  assign l0_res_waddr = r0_q.waddr;
  assign l0_res_wdata = r0_q.wdata;
  assign l1_res_wren = r1_q.wren;
  assign l1_res_waddr = r1_q.waddr;
  assign l1_res_wdata = r1_q.wdata;

endmodule

/* mem_subsystem_top.sv */
`timescale 1ns/100ps

module mem_subsystem_top (
  input  logic clock,
  input  logic reset,
  input  logic clear,
  input  mem_op_pkg::lane_op_e l0_op,
  input  mem_op_pkg::lsu_size_e l0_size,
  input  logic l0_unsigned_ld,
  input  mem_data_pkg::addr_t l0_addr,
  input  mem_data_pkg::word_t l0_data,
  input  mem_op_pkg::reg_addr_t l0_waddr,
  input  mem_op_pkg::lane_op_e l1_op,
  input  mem_op_pkg::lsu_size_e l1_size,
  input  logic l1_unsigned_ld,
  input  mem_data_pkg::addr_t l1_addr,
  input  mem_data_pkg::word_t l1_data,
  input  mem_op_pkg::reg_addr_t l1_waddr,
  output logic stall,
  output logic l0_res_wren,
  output mem_op_pkg::reg_addr_t l0_res_waddr,
  output mem_data_pkg::word_t l0_res_wdata,
  output logic l1_res_wren,
  output mem_op_pkg::reg_addr_t l1_res_waddr,
  output mem_data_pkg::word_t l1_res_wdata
);
  import mem_data_pkg::*;

  logic mem0_valid, mem0_fence, mem0_ready;
  logic mem1_valid, mem1_fence, mem1_ready;
  addr_t mem0_addr, mem1_addr;
  word_t mem0_wdata, mem1_wdata, mem0_rdata, mem1_rdata;
  strb_t mem0_wstrb, mem1_wstrb;

  memory_stage u_stage (.*);

  // One bank per lane
  dtim_bank u_bank0 (
    .clock(clock), .reset(reset),
    .mem_valid(mem0_valid), .mem_fence(mem0_fence), .mem_addr(mem0_addr),
    .mem_wdata(mem0_wdata), .mem_wstrb(mem0_wstrb),
    .mem_ready(mem0_ready), .mem_rdata(mem0_rdata)
  );

  dtim_bank u_bank1 (
    .clock(clock), .reset(reset),
    .mem_valid(mem1_valid), .mem_fence(mem1_fence), .mem_addr(mem1_addr),
    .mem_wdata(mem1_wdata), .mem_wstrb(mem1_wstrb),
    .mem_ready(mem1_ready), .mem_rdata(mem1_rdata)
  );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clock,
  output logic reset
);
  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock; // 10 ns period
  end

  initial begin
    reset = 1'b0;
    repeat (2) @(posedge clock);
    @(negedge clock) reset = 1'b1;
  end

endmodule

/* mem_subsystem_tb.sv */
`timescale 1ns/100ps

`include "dual_mem_stage_cfg.svh"

module mem_subsystem_tb;
  import mem_op_pkg::*;
  import mem_data_pkg::*;

  localparam int N_OPS = 24;
  localparam int TIMEOUT_CYCLES = 40 * N_OPS;
  localparam int BANK_BYTES = `DMS_DTIM_DEPTH * 4;

  logic clock, reset, clear, stall;
  lane_op_e l0_op, l1_op;
  lsu_size_e l0_size, l1_size;
  logic l0_unsigned_ld, l1_unsigned_ld;
  addr_t l0_addr, l1_addr;
  word_t l0_data, l1_data;
  reg_addr_t l0_waddr, l1_waddr;
  logic l0_res_wren, l1_res_wren;
  reg_addr_t l0_res_waddr, l1_res_waddr;
  word_t l0_res_wdata, l1_res_wdata;

  logic [7:0] model [2][BANK_BYTES]; // Reference bytes per bank
  int error_count = 0;
  int cycle_count = 0;

  tb_clock_gen u_clk (.clock(clock), .reset(reset));

  mem_subsystem_top UUT (.*);

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Compare tasks

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      error_count++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_waddr(input string name, input reg_addr_t exp, input reg_addr_t act);
    if (act !== exp) begin
      error_count++;
      $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      error_count++;
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  ////////////////////////////////////////
  // Reference model

  function automatic logic needs_bank(input lane_op_e op);
    return op == OP_LOAD || op == OP_STORE || op == OP_FENCE;
  endfunction

  function automatic logic makes_result(input lane_op_e op);
    return op == OP_ALU || op == OP_LOAD;
  endfunction

  function automatic word_t expected_load(input int bank, input addr_t a, input lsu_size_e sz,
                                          input logic uns);
    int i;
    logic [15:0] h;
    i = a % BANK_BYTES;
    case (sz)
      SZ_BYTE: return uns ? {24'h0, model[bank][i]} : {{24{model[bank][i][7]}}, model[bank][i]};
      SZ_HALF: begin
        i = i & ~1;
        h = {model[bank][i+1], model[bank][i]};
        return uns ? {16'h0, h} : {{16{h[15]}}, h};
      end
      default: begin
        i = i & ~3;
        return {model[bank][i+3], model[bank][i+2], model[bank][i+1], model[bank][i]};
      end
    endcase
  endfunction

  task automatic store_model(input int bank, input addr_t a, input lsu_size_e sz, input word_t d);
    int i;
    i = a % BANK_BYTES;
    case (sz)
      SZ_BYTE: model[bank][i] = d[7:0];
      SZ_HALF: begin
        i = i & ~1;
        model[bank][i] = d[7:0];
        model[bank][i+1] = d[15:8];
      end
      default: begin
        i = i & ~3;
        for (int b = 0; b < 4; b++) model[bank][i+b] = d[b*8 +: 8];
      end
    endcase
  endtask

  ////////////////////////////////////////
  // Stimulus

  task automatic idle_lanes();
    l0_op = OP_NONE;
    l1_op = OP_NONE;
  endtask

  // One operation per lane, held through the stall, then checked
  task automatic run_pair(input string name,
      input lane_op_e op0, input lsu_size_e sz0, input logic uns0, input addr_t a0,
      input word_t d0, input reg_addr_t wa0,
      input lane_op_e op1, input lsu_size_e sz1, input logic uns1, input addr_t a1,
      input word_t d1, input reg_addr_t wa1);
    int stall_cycles;
    logic kill;
    logic exp_wren0, exp_wren1;
    word_t exp0, exp1;
    stall_cycles = 0;
    kill = (op0 == OP_FENCE);
    exp_wren0 = makes_result(op0);
    exp_wren1 = makes_result(op1) && !kill;
    exp0 = (op0 == OP_LOAD) ? expected_load(0, a0, sz0, uns0) : d0;
    exp1 = (op1 == OP_LOAD) ? expected_load(1, a1, sz1, uns1) : d1;
    @(negedge clock);
    l0_op = op0;
    l0_size = sz0;
    l0_unsigned_ld = uns0;
    l0_addr = a0;
    l0_data = d0;
    l0_waddr = wa0;
    l1_op = op1;
    l1_size = sz1;
    l1_unsigned_ld = uns1;
    l1_addr = a1;
    l1_data = d1;
    l1_waddr = wa1;
    #1;
    while (stall) begin
      stall_cycles++;
      @(negedge clock);
      #1;
    end
    @(negedge clock);
    idle_lanes();
    if (needs_bank(op0) || (needs_bank(op1) && !kill))
      check_word({name, " stall cycles"}, `DMS_DTIM_WAIT, stall_cycles);
    else
      check_word({name, " stall cycles"}, 0, stall_cycles);
    check_flag({name, " l0 wren"}, exp_wren0, l0_res_wren);
    check_flag({name, " l1 wren"}, exp_wren1, l1_res_wren);
    if (exp_wren0) begin
      check_waddr({name, " l0 waddr"}, wa0, l0_res_waddr);
      check_word({name, " l0 wdata"}, exp0, l0_res_wdata);
    end
    if (exp_wren1) begin
      check_waddr({name, " l1 waddr"}, wa1, l1_res_waddr);
      check_word({name, " l1 wdata"}, exp1, l1_res_wdata);
    end
    if (op0 == OP_STORE) store_model(0, a0, sz0, d0);
    if (op1 == OP_STORE && !kill) store_model(1, a1, sz1, d1);
  endtask

  ////////////////////////////////////////
  // Directed tests

  addr_t w0, w1; // Word base per bank

  task automatic test_reset();
    check_flag("reset stall", 1'b0, stall);
    check_flag("reset l0 wren", 1'b0, l0_res_wren);
    check_flag("reset l1 wren", 1'b0, l1_res_wren);
  endtask

  task automatic test_alu();
    run_pair("alu", OP_ALU, SZ_WORD, 1'b0, $urandom, $urandom, $urandom,
             OP_ALU, SZ_WORD, 1'b0, $urandom, $urandom, $urandom);
  endtask

  task automatic test_store_load();
    addr_t boff, hoff;
    boff = $urandom_range(0, 3);
    hoff = {$urandom_range(0, 1), 1'b0};
    run_pair("store word", OP_STORE, SZ_WORD, 1'b0, w0, $urandom, 1,
             OP_STORE, SZ_WORD, 1'b0, w1, $urandom, 2);
    run_pair("store byte", OP_STORE, SZ_BYTE, 1'b0, w0 + boff, $urandom, 3,
             OP_STORE, SZ_BYTE, 1'b0, w1 + boff, $urandom, 4);
    run_pair("store half", OP_STORE, SZ_HALF, 1'b0, w0 + hoff, $urandom, 5,
             OP_STORE, SZ_HALF, 1'b0, w1 + hoff, $urandom, 6);
    for (int off = 0; off < 4; off++) begin
      for (int u = 0; u < 2; u++) begin
        run_pair("load byte", OP_LOAD, SZ_BYTE, u[0], w0 + off, 0, $urandom,
                 OP_LOAD, SZ_BYTE, u[0], w1 + off, 0, $urandom);
      end
    end
    for (int off = 0; off < 4; off += 2) begin
      for (int u = 0; u < 2; u++) begin
        run_pair("load half", OP_LOAD, SZ_HALF, u[0], w0 + off, 0, $urandom,
                 OP_LOAD, SZ_HALF, u[0], w1 + off, 0, $urandom);
      end
    end
    run_pair("load word", OP_LOAD, SZ_WORD, 1'b0, w0, 0, $urandom,
             OP_LOAD, SZ_WORD, 1'b0, w1, 0, $urandom);
  endtask

  task automatic test_fence();
    run_pair("fence", OP_FENCE, SZ_WORD, 1'b0, 0, 0, 7,
             OP_LOAD, SZ_WORD, 1'b0, w1, 0, 8);
    run_pair("fence replay", OP_NONE, SZ_WORD, 1'b0, 0, 0, 0,
             OP_LOAD, SZ_WORD, 1'b0, w1, 0, 8);
  endtask

  task automatic test_clear();
    @(negedge clock);
    l0_op = OP_STORE;
    l0_size = SZ_WORD;
    l0_addr = w0;
    l0_data = ~expected_load(0, w0, SZ_WORD, 1'b0); // Every byte differs from the bank
    l1_op = OP_LOAD;
    l1_size = SZ_WORD;
    l1_addr = w1;
    l1_waddr = 11;
    repeat (`DMS_DTIM_WAIT) @(negedge clock);
    clear = 1'b1; // Both banks are in their ready cycle
    #1;
    check_flag("clear stall", 1'b0, stall);
    @(negedge clock);
    clear = 1'b0;
    idle_lanes();
    #1;
    check_flag("clear l0 wren", 1'b0, l0_res_wren);
    check_flag("clear l1 wren", 1'b0, l1_res_wren);
    run_pair("clear readback", OP_LOAD, SZ_WORD, 1'b0, w0, 0, 9,
             OP_LOAD, SZ_WORD, 1'b0, w1, 0, 10);
  endtask

  initial begin
    void'($urandom(32'h91b048b0));
    clear = 1'b0;
    l0_op = OP_NONE;
    l0_size = SZ_WORD;
    l0_unsigned_ld = 1'b0;
    l0_addr = '0;
    l0_data = '0;
    l0_waddr = '0;
    l1_op = OP_NONE;
    l1_size = SZ_WORD;
    l1_unsigned_ld = 1'b0;
    l1_addr = '0;
    l1_data = '0;
    l1_waddr = '0;
    w0 = {$urandom_range(0, `DMS_DTIM_DEPTH - 1), 2'b00};
    w1 = {$urandom_range(0, `DMS_DTIM_DEPTH - 1), 2'b00};
    wait (reset === 1'b1);
    #1; // Before the first edge out of reset
    test_reset();
    test_alu();
    test_store_load();
    test_fence();
    test_clear();
    $display("Errors: %0d", error_count);
    if (error_count == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

/* dual_mem_stage.f */
+incdir+.
mem_op_pkg.sv
mem_data_pkg.sv
lsu_align.sv
dtim_wait_timer.sv
dtim_bank.sv
stage_ctrl_fsm.sv
memory_stage.sv
mem_subsystem_top.sv
tb_clock_gen.sv
mem_subsystem_tb.sv

/* Bender.yml */
package:
  name: dual_mem_stage

export_include_dirs:
  - .

sources:
  - mem_op_pkg.sv
  - mem_data_pkg.sv
  - lsu_align.sv
  - dtim_wait_timer.sv
  - dtim_bank.sv
  - stage_ctrl_fsm.sv
  - memory_stage.sv
  - mem_subsystem_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - mem_subsystem_tb.sv
